// ==== common/sid_pkg.sv ====
package sid_pkg;

    // ====================
    // Sizes
    // ====================
    localparam int NUM_VOICES = 3;
    localparam int PHASE_W    = 16;
    localparam int ENV_W      = 4;
    localparam int LFSR_W     = 4;
    localparam int PRESCALE_W = 20;
    // Fastest envelope rate needs this many prescaler ones
    localparam int TICK_BASE  = 6;
    localparam int SAMPLE_W   = 8;
    localparam int MIX_W      = 10;

    // Reset and limit values
    localparam int LFSR_SEED  = 1;
    localparam int ENV_MAX    = 15;

    // ====================
    // Waveform register bits
    // ====================
    localparam int WF_GATE  = 0;
    localparam int WF_TEST  = 3;
    localparam int WF_TRI   = 4;
    localparam int WF_SAW   = 5;
    localparam int WF_PULSE = 6;
    localparam int WF_NOISE = 7;

    // ====================
    // Types
    // ====================
    typedef logic [1:0]          voice_idx_t;
    typedef logic [PHASE_W-1:0]  phase_t;
    typedef logic [ENV_W-1:0]    env_t;
    typedef logic [LFSR_W-1:0]   lfsr_t;
    typedef logic [SAMPLE_W-1:0] sample_t;
    typedef logic [7:0]          byte_t;

    // Per-voice register map, addresses 3 and 7 are holes
    typedef enum logic [2:0] {
        FREQ_LO         = 3'd0,
        FREQ_HI         = 3'd1,
        PULSE_WIDTH     = 3'd2,
        ATTACK_DECAY    = 3'd4,
        SUSTAIN_RELEASE = 3'd5,
        WAVEFORM        = 3'd6
    } reg_addr_e;

    typedef enum logic [1:0] {
        ENV_IDLE    = 2'd0,
        ENV_ATTACK  = 2'd1,
        ENV_DECAY   = 2'd2,
        ENV_RELEASE = 2'd3
    } env_state_e;

endpackage

// ==== hdl/sid_reg_file.sv ====
`timescale 1ns/1ps

module sid_reg_file import sid_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       wr_en,
    input  voice_idx_t voice_sel,
    input  reg_addr_e  reg_addr,
    input  byte_t      wr_data,
    input  voice_idx_t cur_voice,
    output phase_t     frequency,
    output byte_t      pulse_width,
    output byte_t      attack_decay,
    output byte_t      sustain_release,
    output byte_t      waveform
);

    // ====================
    // Write strobe edge
    // ====================
    logic wr_en_d;
    logic wr_rise;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_en_d <= 1'b0;
        end else begin
            wr_en_d <= wr_en;
        end
    end

    // Only the first cycle of a held strobe counts
    assign wr_rise = wr_en && !wr_en_d;

    // ====================
    // Register banks
    // ====================
    phase_t freq_q    [NUM_VOICES];
    byte_t  pw_q      [NUM_VOICES];
    byte_t  ad_q      [NUM_VOICES];
    byte_t  sr_q      [NUM_VOICES];
    byte_t  wf_q      [NUM_VOICES];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int v = 0; v < NUM_VOICES; v++) begin
                freq_q[v] <= '0;
                pw_q[v]   <= '0;
                ad_q[v]   <= '0;
                sr_q[v]   <= '0;
                wf_q[v]   <= '0;
            end
        end else begin
            // Voice 3 matches no bank and is dropped
            for (int v = 0; v < NUM_VOICES; v++) begin
                if (wr_rise && (voice_sel == voice_idx_t'(v))) begin
                    case (reg_addr)
                        FREQ_LO:         freq_q[v][7:0]  <= wr_data;
                        FREQ_HI:         freq_q[v][15:8] <= wr_data;
                        PULSE_WIDTH:     pw_q[v]         <= wr_data;
                        ATTACK_DECAY:    ad_q[v]         <= wr_data;
                        SUSTAIN_RELEASE: sr_q[v]         <= wr_data;
                        WAVEFORM:        wf_q[v]         <= wr_data;
                        default: ;
                    endcase
                end
            end
        end
    end

    // Present the bank of the voice in service
    always_comb begin
        frequency       = '0;
        pulse_width     = '0;
        attack_decay    = '0;
        sustain_release = '0;
        waveform        = '0;
        for (int v = 0; v < NUM_VOICES; v++) begin
            if (cur_voice == voice_idx_t'(v)) begin
                frequency       = freq_q[v];
                pulse_width     = pw_q[v];
                attack_decay    = ad_q[v];
                sustain_release = sr_q[v];
                waveform        = wf_q[v];
            end
        end
    end

endmodule

// ==== voice/voice_sequencer.sv ====
`timescale 1ns/1ps

module voice_sequencer import sid_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    output voice_idx_t            cur_voice,
    output logic [PRESCALE_W-1:0] prescaler
);

    // Round-robin 0, 1, 2 and back
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_voice <= '0;
        end else if (cur_voice == voice_idx_t'(NUM_VOICES - 1)) begin
            cur_voice <= '0;
        end else begin
            cur_voice <= cur_voice + 1'b1;
        end
    end

    // Free-running envelope prescaler, wraps at 2^20
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prescaler <= '0;
        end else begin
            prescaler <= prescaler + 1'b1;
        end
    end

endmodule

// ==== voice/voice_state_bank.sv ====
`timescale 1ns/1ps

module voice_state_bank import sid_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  voice_idx_t cur_voice,
    input  phase_t     nxt_phase,
    input  lfsr_t      nxt_lfsr,
    input  env_t       nxt_env,
    input  env_state_e nxt_state,
    input  logic       gate,
    output phase_t     phase,
    output lfsr_t      lfsr,
    output env_t       env,
    output env_state_e state,
    output logic       last_gate
);

    // One slot per voice
    phase_t     phase_q [NUM_VOICES];
    lfsr_t      lfsr_q  [NUM_VOICES];
    env_t       env_q   [NUM_VOICES];
    env_state_e state_q [NUM_VOICES];
    logic       gate_q  [NUM_VOICES];

    // ====================
    // Write back
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int v = 0; v < NUM_VOICES; v++) begin
                phase_q[v] <= '0;
                lfsr_q[v]  <= lfsr_t'(LFSR_SEED);
                env_q[v]   <= '0;
                state_q[v] <= ENV_IDLE;
                gate_q[v]  <= 1'b0;
            end
        end else begin
            // Only the slot in service moves
            for (int v = 0; v < NUM_VOICES; v++) begin
                if (cur_voice == voice_idx_t'(v)) begin
                    phase_q[v] <= nxt_phase;
                    lfsr_q[v]  <= nxt_lfsr;
                    env_q[v]   <= nxt_env;
                    state_q[v] <= nxt_state;
                    gate_q[v]  <= gate;
                end
            end
        end
    end

    // ====================
    // Read current slot
    // ====================
    always_comb begin
        phase     = '0;
        lfsr      = lfsr_t'(LFSR_SEED);
        env       = '0;
        state     = ENV_IDLE;
        last_gate = 1'b0;
        for (int v = 0; v < NUM_VOICES; v++) begin
            if (cur_voice == voice_idx_t'(v)) begin
                phase     = phase_q[v];
                lfsr      = lfsr_q[v];
                env       = env_q[v];
                state     = state_q[v];
                last_gate = gate_q[v];
            end
        end
    end

endmodule

// ==== voice/waveform_gen.sv ====
`timescale 1ns/1ps

module waveform_gen import sid_pkg::*; (
    input  phase_t phase,
    input  lfsr_t  lfsr,
    input  phase_t frequency,
    input  byte_t  pulse_width,
    input  byte_t  waveform,
    output phase_t nxt_phase,
    output lfsr_t  nxt_lfsr,
    output byte_t  wave
);

    logic  test;
    byte_t saw;
    byte_t tri_w;
    byte_t tri_fold;
    logic  pulse_hi;

    assign test = waveform[WF_TEST];

    // ====================
    // Oscillator update
    // ====================
    // Test holds the phase at 0 and reseeds the noise
    assign nxt_phase = test ? '0 : phase + frequency;
    assign nxt_lfsr  = test ? lfsr_t'(LFSR_SEED) : {lfsr[2:0], lfsr[1] ^ lfsr[3]};

    // ====================
    // Waveforms
    // ====================
    assign saw      = phase[PHASE_W-1 -: 8];
    // Fold on the MSB unless sawtooth is also on
    assign tri_fold = {8{phase[PHASE_W-1] & ~waveform[WF_SAW]}};
    assign tri_w    = phase[PHASE_W-2 -: 8] ^ tri_fold;
    assign pulse_hi = saw > pulse_width;

    // Enabled waveforms are ORed together
    always_comb begin
        wave = '0;
        if (waveform[WF_TRI])   wave = wave | tri_w;
        if (waveform[WF_SAW])   wave = wave | saw;
        if (waveform[WF_PULSE]) wave = wave | {8{pulse_hi}};
        if (waveform[WF_NOISE]) wave = wave | {lfsr, lfsr};
    end

endmodule

// ==== voice/adsr_envelope.sv ====
`timescale 1ns/1ps

module adsr_envelope import sid_pkg::*; (
    input  env_state_e            state,
    input  env_t                  env,
    input  logic                  last_gate,
    input  byte_t                 waveform,
    input  byte_t                 attack_decay,
    input  byte_t                 sustain_release,
    input  logic [PRESCALE_W-1:0] prescaler,
    output env_state_e            nxt_state,
    output env_t                  nxt_env,
    output logic                  gate
);

    logic [3:0] rate;
    logic       tick;
    logic       new_gate;
    env_t       sustain_lvl;

    assign gate        = waveform[WF_GATE];
    assign new_gate    = gate && !last_gate;
    assign sustain_lvl = sustain_release[3:0];

    // ====================
    // Rate and tick
    // ====================
    always_comb begin
        case (state)
            ENV_ATTACK:  rate = attack_decay[3:0];
            ENV_DECAY:   rate = attack_decay[7:4];
            ENV_RELEASE: rate = sustain_release[7:4];
            default:     rate = 4'd0;
        endcase
    end

    // Tick when the low TICK_BASE+rate prescaler bits are all ones
    always_comb begin
        int                    nbits;
        logic [PRESCALE_W-1:0] mask;
        nbits = TICK_BASE + int'(rate);
        // Clamp to the counter width, rate 15 acts as 14
        if (nbits > PRESCALE_W) nbits = PRESCALE_W;
        for (int i = 0; i < PRESCALE_W; i++) begin
            mask[i] = (i < nbits);
        end
        tick = &(prescaler | ~mask);
    end

    // ====================
    // Envelope FSM
    // ====================
    always_comb begin
        nxt_state = state;
        nxt_env   = env;
        case (state)
            ENV_IDLE: begin
                nxt_env = '0;
                if (new_gate) nxt_state = ENV_ATTACK;
            end
            ENV_ATTACK: begin
                if (!gate)                      nxt_state = ENV_RELEASE;
                else if (env == env_t'(ENV_MAX)) nxt_state = ENV_DECAY;
                else if (tick)                  nxt_env = env + 1'b1;
            end
            ENV_DECAY: begin
                if (!gate)                          nxt_state = ENV_RELEASE;
                else if (env > sustain_lvl && tick) nxt_env = env - 1'b1;
            end
            default: begin
                // Release, retrigger wins over the fade
                if (new_gate)       nxt_state = ENV_ATTACK;
                else if (env == '0) nxt_state = ENV_IDLE;
                else if (tick)      nxt_env = env - 1'b1;
            end
        endcase
    end

endmodule

// ==== hdl/voice_mixer.sv ====
`timescale 1ns/1ps

module voice_mixer import sid_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  voice_idx_t cur_voice,
    input  byte_t      wave,
    input  env_t       env,
    output sample_t    sample,
    output logic       sample_valid
);

    logic [SAMPLE_W+ENV_W-1:0] product;
    logic [MIX_W-1:0]          scaled;
    logic [MIX_W-1:0]          mix_acc;

    // Waveform times level, keep the upper 8 bits
    assign product = wave * env;
    assign scaled  = MIX_W'(product[SAMPLE_W+ENV_W-1 -: SAMPLE_W]);

    // ====================
    // Accumulate and latch
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mix_acc      <= '0;
            sample       <= '0;
            sample_valid <= 1'b0;
        end else if (cur_voice == '0) begin
            // Voice 0 closes the previous frame
            sample       <= mix_acc[MIX_W-1 -: SAMPLE_W];
            mix_acc      <= scaled;
            sample_valid <= 1'b1;
        end else begin
            mix_acc      <= mix_acc + scaled;
            sample_valid <= 1'b0;
        end
    end

endmodule

// ==== hdl/sid_top.sv ====
`timescale 1ns/1ps

module sid_top import sid_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       wr_en,
    input  voice_idx_t voice_sel,
    input  reg_addr_e  reg_addr,
    input  byte_t      wr_data,
    output sample_t    sample,
    output logic       sample_valid
);

    // Shared sequencing
    voice_idx_t            cur_voice;
    logic [PRESCALE_W-1:0] prescaler;

    // Registers of the voice in service
    phase_t frequency;
    byte_t  pulse_width;
    byte_t  attack_decay;
    byte_t  sustain_release;
    byte_t  waveform;

    // Current and next voice state
    phase_t     phase;
    phase_t     nxt_phase;
    lfsr_t      lfsr;
    lfsr_t      nxt_lfsr;
    env_t       env;
    env_t       nxt_env;
    env_state_e state;
    env_state_e nxt_state;
    logic       last_gate;
    logic       gate;
    byte_t      wave;

    // ====================
    // Blocks
    // ====================
    sid_reg_file u_reg_file (
        .clk(clk), .rst_n(rst_n),
        .wr_en(wr_en), .voice_sel(voice_sel), .reg_addr(reg_addr), .wr_data(wr_data),
        .cur_voice(cur_voice),
        .frequency(frequency), .pulse_width(pulse_width), .attack_decay(attack_decay),
        .sustain_release(sustain_release), .waveform(waveform)
    );

    voice_sequencer u_sequencer (
        .clk(clk), .rst_n(rst_n), .cur_voice(cur_voice), .prescaler(prescaler)
    );

    voice_state_bank u_state_bank (
        .clk(clk), .rst_n(rst_n), .cur_voice(cur_voice),
        .nxt_phase(nxt_phase), .nxt_lfsr(nxt_lfsr), .nxt_env(nxt_env),
        .nxt_state(nxt_state), .gate(gate),
        .phase(phase), .lfsr(lfsr), .env(env), .state(state), .last_gate(last_gate)
    );

    waveform_gen u_waveform (
        .phase(phase), .lfsr(lfsr), .frequency(frequency), .pulse_width(pulse_width),
        .waveform(waveform), .nxt_phase(nxt_phase), .nxt_lfsr(nxt_lfsr), .wave(wave)
    );

    adsr_envelope u_envelope (
        .state(state), .env(env), .last_gate(last_gate), .waveform(waveform),
        .attack_decay(attack_decay), .sustain_release(sustain_release),
        .prescaler(prescaler),
        .nxt_state(nxt_state), .nxt_env(nxt_env), .gate(gate)
    );

    voice_mixer u_mixer (
        .clk(clk), .rst_n(rst_n), .cur_voice(cur_voice), .wave(wave), .env(env),
        .sample(sample), .sample_valid(sample_valid)
    );

endmodule

// ==== test/sid_asserts.sv ====
`timescale 1ns/1ps

module sid_asserts (
    input logic clk,
    input logic rst_n,
    input logic sample_valid
);

    // Count of failed checks
    int unsigned assert_errors = 0;

    // ====================
    // Strobe spacing
    // ====================
    no_double: assert property (@(posedge clk) disable iff (!rst_n)
        sample_valid |-> !$past(sample_valid))
        else begin
            assert_errors = assert_errors + 1;
            $error("sample_valid high in two consecutive cycles");
        end

    // Two quiet cycles, then the next strobe
    frame_gap: assert property (@(posedge clk) disable iff (!rst_n)
        $past(sample_valid, 3) |-> (sample_valid && !$past(sample_valid, 2)))
        else begin
            assert_errors = assert_errors + 1;
            $error("sample_valid not spaced by exactly two idle cycles");
        end

    in_reset: assert property (@(posedge clk) !rst_n |-> !sample_valid)
        else begin
            assert_errors = assert_errors + 1;
            $error("sample_valid high during reset");
        end

endmodule

bind sid_top sid_asserts u_asserts (
    .clk(clk),
    .rst_n(rst_n),
    .sample_valid(sample_valid)
);

// ==== test/sid_ref_model.svh ====
`ifndef SID_REF_MODEL_SVH
`define SID_REF_MODEL_SVH

// ====================
// Model state
// ====================
// Register banks
phase_t     mdl_freq  [NUM_VOICES];
byte_t      mdl_pw    [NUM_VOICES];
byte_t      mdl_ad    [NUM_VOICES];
byte_t      mdl_sr    [NUM_VOICES];
byte_t      mdl_wf    [NUM_VOICES];
// Oscillator and envelope slots
phase_t     mdl_phase [NUM_VOICES];
lfsr_t      mdl_lfsr  [NUM_VOICES];
env_t       mdl_env   [NUM_VOICES];
env_state_e mdl_state [NUM_VOICES];
logic       mdl_gate  [NUM_VOICES];
// Sequencing and mixer
logic        mdl_wr_d;
int          mdl_voice;
int unsigned mdl_pre;
int          mdl_acc;
sample_t     mdl_sample;
logic        mdl_valid;

task automatic reset_model();
    for (int v = 0; v < NUM_VOICES; v++) begin
        mdl_freq[v]  = '0;
        mdl_pw[v]    = '0;
        mdl_ad[v]    = '0;
        mdl_sr[v]    = '0;
        mdl_wf[v]    = '0;
        mdl_phase[v] = '0;
        mdl_lfsr[v]  = lfsr_t'(LFSR_SEED);
        mdl_env[v]   = '0;
        mdl_state[v] = ENV_IDLE;
        mdl_gate[v]  = 1'b0;
    end
    mdl_wr_d   = 1'b0;
    mdl_voice  = 0;
    mdl_pre    = 0;
    mdl_acc    = 0;
    mdl_sample = '0;
    mdl_valid  = 1'b0;
endtask

// One clock edge, inputs as seen just before the edge
task automatic step_model(input logic wr, input voice_idx_t vs, input reg_addr_e ra,
                          input byte_t d);
    int          v;
    byte_t       wf;
    byte_t       saw;
    byte_t       tri_v;
    byte_t       wave;
    int          scaled;
    int          rate;
    int          nbits;
    int unsigned ones;
    logic        tick;
    logic        gate;
    logic        trig;
    v  = mdl_voice;
    wf = mdl_wf[v];

    // Waveform from the old phase and noise
    saw   = mdl_phase[v][15:8];
    tri_v = mdl_phase[v][14:7];
    if (mdl_phase[v][15] && !wf[WF_SAW]) tri_v = ~tri_v;
    wave = 8'h00;
    if (wf[WF_TRI]) wave = wave | tri_v;
    if (wf[WF_SAW]) wave = wave | saw;
    if (wf[WF_PULSE] && (saw > mdl_pw[v])) wave = 8'hFF;
    if (wf[WF_NOISE]) wave = wave | {mdl_lfsr[v], mdl_lfsr[v]};
    // Top 8 of the 12-bit product
    scaled = (int'(wave) * int'(mdl_env[v])) / 16;

    // Frame closes on voice 0
    if (v == 0) begin
        mdl_sample = sample_t'(mdl_acc / 4);
        mdl_acc    = scaled;
        mdl_valid  = 1'b1;
    end else begin
        mdl_acc   = mdl_acc + scaled;
        mdl_valid = 1'b0;
    end

    // ====================
    // Envelope
    // ====================
    gate = wf[WF_GATE];
    trig = gate && !mdl_gate[v];
    case (mdl_state[v])
        ENV_ATTACK:  rate = int'(mdl_ad[v][3:0]);
        ENV_DECAY:   rate = int'(mdl_ad[v][7:4]);
        ENV_RELEASE: rate = int'(mdl_sr[v][7:4]);
        default:     rate = 0;
    endcase
    nbits = (TICK_BASE + rate > PRESCALE_W) ? PRESCALE_W : TICK_BASE + rate;
    ones  = (32'd1 << nbits) - 32'd1;
    tick  = (mdl_pre & ones) == ones;
    case (mdl_state[v])
        ENV_IDLE: begin
            mdl_env[v] = '0;
            if (trig) mdl_state[v] = ENV_ATTACK;
        end
        ENV_ATTACK: begin
            if (!gate) mdl_state[v] = ENV_RELEASE;
            else if (mdl_env[v] == env_t'(ENV_MAX)) mdl_state[v] = ENV_DECAY;
            else if (tick) mdl_env[v] = mdl_env[v] + 4'd1;
        end
        ENV_DECAY: begin
            if (!gate) mdl_state[v] = ENV_RELEASE;
            else if (tick && (mdl_env[v] > mdl_sr[v][3:0])) mdl_env[v] = mdl_env[v] - 4'd1;
        end
        default: begin
            if (trig) mdl_state[v] = ENV_ATTACK;
            else if (mdl_env[v] == 4'd0) mdl_state[v] = ENV_IDLE;
            else if (tick) mdl_env[v] = mdl_env[v] - 4'd1;
        end
    endcase
    mdl_gate[v] = gate;

    // Oscillator, test bit holds it cleared
    if (wf[WF_TEST]) begin
        mdl_phase[v] = '0;
        mdl_lfsr[v]  = lfsr_t'(LFSR_SEED);
    end else begin
        mdl_phase[v] = mdl_phase[v] + mdl_freq[v];
        mdl_lfsr[v]  = {mdl_lfsr[v][2:0], mdl_lfsr[v][1] ^ mdl_lfsr[v][3]};
    end

    // Register write on the rising strobe only
    if (wr && !mdl_wr_d && (vs != 2'd3)) begin
        case (ra)
            FREQ_LO:         mdl_freq[vs][7:0]  = d;
            FREQ_HI:         mdl_freq[vs][15:8] = d;
            PULSE_WIDTH:     mdl_pw[vs] = d;
            ATTACK_DECAY:    mdl_ad[vs] = d;
            SUSTAIN_RELEASE: mdl_sr[vs] = d;
            WAVEFORM:        mdl_wf[vs] = d;
            default: ;
        endcase
    end
    mdl_wr_d  = wr;
    mdl_voice = (v + 1) % NUM_VOICES;
    mdl_pre   = (mdl_pre + 32'd1) & 32'h000F_FFFF;
endtask

`endif

// ==== test/tb_sid.sv ====
`timescale 1ns/1ps

module tb_sid import sid_pkg::*; ();

    logic       clk;
    logic       rst_n;
    logic       wr_en;
    voice_idx_t voice_sel;
    reg_addr_e  reg_addr;
    byte_t      wr_data;
    sample_t    sample;
    logic       sample_valid;

    // Last waveform byte written per voice
    byte_t wf_shadow [NUM_VOICES];

    sid_top DUT (
        .clk(clk), .rst_n(rst_n),
        .wr_en(wr_en), .voice_sel(voice_sel), .reg_addr(reg_addr), .wr_data(wr_data),
        .sample(sample), .sample_valid(sample_valid)
    );

    `include "sid_ref_model.svh"

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ====================
    // Checks
    // ====================
    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_sample(input sample_t got, input sample_t exp);
        if (got !== exp)
            stop_run($sformatf("Error at %0t: sample %02h, expected %02h", $time, got, exp));
    endtask

    task automatic check_valid(input logic got, input logic exp);
        if (got !== exp)
            stop_run($sformatf("Error at %0t: sample_valid %b, expected %b", $time, got, exp));
    endtask

    task automatic check_state(input env_state_e got, input env_state_e exp);
        if (got !== exp)
            stop_run($sformatf("Error at %0t: envelope state %s, expected %s",
                               $time, got.name(), exp.name()));
    endtask

    // Idle cycles between strobes
    task automatic check_gap(input int got, input int exp);
        if (got != exp)
            stop_run($sformatf("Error at %0t: strobe after %0d idle cycles, expected %0d",
                               $time, got, exp));
    endtask

    // Outputs still hold the last edge's values here and the model steps after the compare
    always @(posedge clk) begin
        if (!rst_n) begin
            reset_model();
        end else begin
            check_valid(sample_valid, mdl_valid);
            check_sample(sample, mdl_sample);
            step_model(wr_en, voice_sel, reg_addr, wr_data);
        end
        if (DUT.u_asserts.assert_errors != 0) stop_run("a bound assertion on sid_top failed");
    end

    // ====================
    // Stimulus helpers
    // ====================
    // Strobe held for hold cycles while the data keeps changing
    task automatic write_reg(input voice_idx_t v, input reg_addr_e a, input byte_t d,
                             input int hold);
        @(posedge clk);
        wr_en     <= 1'b1;
        voice_sel <= v;
        reg_addr  <= a;
        wr_data   <= d;
        for (int i = 1; i < hold; i++) begin
            @(posedge clk);
            wr_data <= byte_t'($urandom);
        end
        @(posedge clk);
        wr_en <= 1'b0;
    endtask

    function automatic int burst_len();
        return 1 + int'($urandom_range(2));
    endfunction

    task automatic set_wave(input int v, input byte_t wf);
        wf_shadow[v] = wf;
        write_reg(voice_idx_t'(v), WAVEFORM, wf, burst_len());
    endtask

    // Idle cycles counted until the next strobe
    task automatic wait_strobe(output int gap);
        int n;
        n   = 0;
        gap = 0;
        @(negedge clk);
        while (!sample_valid && n < 16) begin
            gap++;
            n++;
            @(negedge clk);
        end
        if (!sample_valid) stop_run("no sample_valid strobe within 16 cycles");
    endtask

    task automatic run_frames(input int frames);
        int gap;
        for (int f = 0; f < frames; f++) begin
            wait_strobe(gap);
        end
    endtask

    function automatic logic all_idle();
        return mdl_state[0] == ENV_IDLE && mdl_state[1] == ENV_IDLE
            && mdl_state[2] == ENV_IDLE;
    endfunction

    task automatic wait_all_idle(input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (!all_idle() && n < limit) begin
            n++;
            @(negedge clk);
        end
        if (!all_idle()) stop_run($sformatf("envelopes not idle after %0d cycles", limit));
    endtask

    // ====================
    // Test sequence
    // ====================
    initial begin
        int gap;
        void'($urandom(16));
        rst_n     = 1'b0;
        wr_en     = 1'b0;
        voice_sel = '0;
        reg_addr  = FREQ_LO;
        wr_data   = '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        // Strobe right after the first edge out of reset, then every third
        wait_strobe(gap);
        check_gap(gap, 1);
        check_sample(sample, '0);
        for (int i = 0; i < 10; i++) begin
            wait_strobe(gap);
            check_gap(gap, 2);
            check_sample(sample, '0);
        end

        // Voice 0 alone, sawtooth, fast attack and decay
        write_reg(2'd0, FREQ_LO, byte_t'($urandom), burst_len());
        write_reg(2'd0, FREQ_HI, byte_t'($urandom_range(15, 1)), burst_len());
        write_reg(2'd0, ATTACK_DECAY, 8'h10, burst_len());
        write_reg(2'd0, SUSTAIN_RELEASE, 8'h08, burst_len());
        set_wave(0, 8'h21);
        run_frames(2000);

        // All voices with random parameters and waveform mixes
        for (int v = 0; v < NUM_VOICES; v++) begin
            write_reg(voice_idx_t'(v), FREQ_LO, byte_t'($urandom), burst_len());
            write_reg(voice_idx_t'(v), FREQ_HI, byte_t'($urandom), burst_len());
            write_reg(voice_idx_t'(v), PULSE_WIDTH, byte_t'($urandom), burst_len());
            write_reg(voice_idx_t'(v), ATTACK_DECAY, byte_t'($urandom) & 8'h33, burst_len());
            write_reg(voice_idx_t'(v), SUSTAIN_RELEASE, byte_t'($urandom) & 8'h1F, burst_len());
            set_wave(v, (byte_t'($urandom) & 8'hF0) | 8'h01);
        end
        run_frames(2000);

        // Gate off on every voice and a fade to idle
        for (int v = 0; v < NUM_VOICES; v++) begin
            write_reg(voice_idx_t'(v), SUSTAIN_RELEASE, byte_t'($urandom_range(31)), burst_len());
            set_wave(v, wf_shadow[v] & 8'hFE);
        end
        wait_all_idle(20000);
        for (int v = 0; v < NUM_VOICES; v++) begin
            check_state(DUT.u_state_bank.state_q[v], mdl_state[v]);
        end
        run_frames(2);
        check_sample(sample, '0);

        // Unused addresses, voice 3 and long held strobes change nothing
        set_wave(0, 8'h21);
        run_frames(100);
        write_reg(2'd0, reg_addr_e'(3'd3), byte_t'($urandom), 5);
        write_reg(2'd1, reg_addr_e'(3'd7), byte_t'($urandom), 5);
        write_reg(2'd3, FREQ_HI, byte_t'($urandom), burst_len());
        write_reg(2'd3, WAVEFORM, 8'hFF, burst_len());
        write_reg(2'd0, FREQ_LO, byte_t'($urandom), 6);
        run_frames(300);

        // Test bit on a noise voice, then release it
        write_reg(2'd1, FREQ_HI, byte_t'($urandom), burst_len());
        write_reg(2'd1, ATTACK_DECAY, 8'h00, burst_len());
        set_wave(1, 8'h89);
        run_frames(300);
        set_wave(1, 8'h81);
        run_frames(500);

        if (DUT.u_asserts.assert_errors != 0) begin
            stop_run("a bound assertion on sid_top failed");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

// ==== sim.f ====
+incdir+test
common/sid_pkg.sv
hdl/sid_reg_file.sv
voice/voice_sequencer.sv
voice/voice_state_bank.sv
voice/waveform_gen.sv
voice/adsr_envelope.sv
hdl/voice_mixer.sv
hdl/sid_top.sv
test/sid_asserts.sv
test/tb_sid.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the synthesizer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_sid -Mdir obj_dir

# Let assertion errors reach the testbench, which then ends the run
./obj_dir/Vtb_sid +verilator+error+limit+100
